// File: common/ldq_params.svh
`ifndef LDQ_PARAMS_SVH
`define LDQ_PARAMS_SVH

`define LDQ_SIZE    4
`define CMT_ID_W    6
`define RNID_W      6
`define BR_TAG_NUM  4   // also the branch mask width
`define STQ_SIZE    4   // width of the store dependence mask
`define PHY_WR_NUM  2
`define PADDR_W     16

`endif

// File: common/core_pkg.sv
`include "ldq_params.svh"

package core_pkg;

  // commit ID, unique among live entries
  typedef logic [`CMT_ID_W-1:0] cmt_id_t;

  // physical register number
  typedef logic [`RNID_W-1:0] rnid_t;

  // one bit per branch tag in flight
  typedef logic [`BR_TAG_NUM-1:0] br_mask_t;

  typedef logic [$clog2(`BR_TAG_NUM)-1:0] br_tag_t;

endpackage

// File: common/ldq_pkg.sv
`include "ldq_params.svh"

package ldq_pkg;

  typedef enum logic [3:0] {
    LDQ_INIT,
    LDQ_ISSUE_WAIT,
    LDQ_ISSUED,
    LDQ_TLB_HAZ,
    LDQ_EX2_RUN,
    LDQ_STQ_HAZ,
    LDQ_EX3_DONE,
    LDQ_WAIT_COMPLETE,
    LDQ_DEAD
  } ldq_state_t;

  typedef struct packed {
    logic                  valid;
    ldq_state_t            state;
    core_pkg::cmt_id_t     cmt_id;
    core_pkg::br_mask_t    br_mask;
    logic                  rs1_valid;
    core_pkg::rnid_t       rs1_rnid;
    logic                  rs1_ready;
    logic [`PADDR_W-1:0]   paddr;
    logic [`STQ_SIZE-1:0]  stq_haz;   // older stores still blocking
  } ldq_entry_t;

  // handed to the load pipe at issue
  typedef struct packed {
    core_pkg::cmt_id_t  cmt_id;
    core_pkg::rnid_t    rs1_rnid;
  } ldq_issue_t;

endpackage

// File: ldq/phy_wr_select.sv
`timescale 1ns/1ps
`include "ldq_params.svh"

module phy_wr_select (
  input  core_pkg::rnid_t          i_rnid,
  input  logic [`PHY_WR_NUM-1:0]   i_phy_wr_valid,
  input  core_pkg::rnid_t          i_phy_wr_rnid [`PHY_WR_NUM],
  output logic                     o_hit
);

  logic [`PHY_WR_NUM-1:0] w_bus_hit;

  // any bus writing this register wakes it
  always_comb begin
    for (int b = 0; b < `PHY_WR_NUM; b++) begin
      w_bus_hit[b] = i_phy_wr_valid[b] & (i_phy_wr_rnid[b] == i_rnid);
    end
  end

  assign o_hit = |w_bus_hit;

endmodule

// File: ldq/ldq_entry.sv
`timescale 1ns/1ps
`include "ldq_params.svh"

module ldq_entry (
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  input  logic                    i_disp_load,
  input  core_pkg::cmt_id_t       i_disp_cmt_id,
  input  core_pkg::br_mask_t      i_disp_br_mask,
  input  logic                    i_disp_rs1_valid,
  input  core_pkg::rnid_t         i_disp_rs1_rnid,
  input  logic                    i_disp_rs1_ready,

  input  logic [`PHY_WR_NUM-1:0]  i_phy_wr_valid,
  input  core_pkg::rnid_t         i_phy_wr_rnid [`PHY_WR_NUM],

  input  logic                    i_picked,

  input  logic                    i_ex1_valid,
  input  logic                    i_ex1_tlb_miss,
  input  logic [`PADDR_W-1:0]     i_ex1_paddr,
  input  logic                    i_tlb_resolve,

  input  logic                    i_ex2_valid,
  input  logic [`STQ_SIZE-1:0]    i_ex2_stq_haz,
  input  logic                    i_stq_resolve_valid,
  input  logic [`STQ_SIZE-1:0]    i_stq_resolve_oh,

  input  logic                    i_commit_valid,
  input  core_pkg::cmt_id_t       i_commit_cmt_id,

  input  logic                    i_br_update,
  input  logic                    i_br_mispredict,
  input  core_pkg::br_tag_t       i_br_tag,

  output ldq_pkg::ldq_entry_t     o_entry,
  output logic                    o_ready,
  output logic                    o_finish
);

  import core_pkg::*;
  import ldq_pkg::*;

  ldq_entry_t            r_entry;
  ldq_entry_t            w_entry_next;
  rnid_t                 w_rs1_rnid;
  logic                  w_rs1_hit;
  logic                  w_br_flush;
  logic                  w_disp_br_flush;
  logic                  w_commit_match;
  logic [`STQ_SIZE-1:0]  w_stq_haz_next;

  assign o_entry = r_entry;

  // look at the incoming operand while it is being written in
  assign w_rs1_rnid = i_disp_load ? i_disp_rs1_rnid : r_entry.rs1_rnid;

  phy_wr_select u_rs1_select (
    .i_rnid          (w_rs1_rnid),
    .i_phy_wr_valid  (i_phy_wr_valid),
    .i_phy_wr_rnid   (i_phy_wr_rnid),
    .o_hit           (w_rs1_hit)
  );

  assign w_br_flush = i_br_update & i_br_mispredict & r_entry.valid &
                      r_entry.br_mask[i_br_tag];
  assign w_disp_br_flush = i_br_update & i_br_mispredict & i_disp_br_mask[i_br_tag];

  assign w_commit_match = i_commit_valid & r_entry.valid &
                          (i_commit_cmt_id == r_entry.cmt_id);

  assign w_stq_haz_next = i_stq_resolve_valid ? (r_entry.stq_haz & ~i_stq_resolve_oh) :
                          r_entry.stq_haz;

  assign o_ready = (r_entry.state == LDQ_ISSUE_WAIT) & ~w_br_flush &
                   (~r_entry.rs1_valid | r_entry.rs1_ready);

  assign o_finish = w_commit_match &
                    ((r_entry.state == LDQ_WAIT_COMPLETE) | (r_entry.state == LDQ_DEAD));

  always_comb begin
    w_entry_next = r_entry;
    w_entry_next.rs1_ready = r_entry.rs1_ready | w_rs1_hit;
    if (i_br_update) begin
      w_entry_next.br_mask[i_br_tag] = 1'b0;  // branch resolved
    end

    case (r_entry.state)
      LDQ_INIT: begin
        if (i_disp_load) begin
          w_entry_next.valid     = 1'b1;
          w_entry_next.cmt_id    = i_disp_cmt_id;
          w_entry_next.br_mask   = i_disp_br_mask;
          w_entry_next.rs1_valid = i_disp_rs1_valid;
          w_entry_next.rs1_rnid  = i_disp_rs1_rnid;
          w_entry_next.rs1_ready = i_disp_rs1_ready | w_rs1_hit;
          w_entry_next.stq_haz   = '0;
          if (i_br_update) begin
            w_entry_next.br_mask[i_br_tag] = 1'b0;
          end
          w_entry_next.state = w_disp_br_flush ? LDQ_DEAD : LDQ_ISSUE_WAIT;
        end
      end
      LDQ_ISSUE_WAIT: begin
        if (w_br_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else if (o_ready & i_picked) begin
          w_entry_next.state = LDQ_ISSUED;
        end
      end
      LDQ_ISSUED: begin
        if (w_br_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else if (i_ex1_valid) begin
          w_entry_next.state = i_ex1_tlb_miss ? LDQ_TLB_HAZ : LDQ_EX2_RUN;
          w_entry_next.paddr = i_ex1_paddr;
        end
      end
      LDQ_TLB_HAZ: begin
        if (w_br_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else if (i_tlb_resolve) begin
          w_entry_next.state = LDQ_ISSUE_WAIT;  // replay from issue
        end
      end
      LDQ_EX2_RUN: begin
        if (w_br_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else if (i_ex2_valid) begin
          w_entry_next.stq_haz = i_ex2_stq_haz;
          w_entry_next.state   = (|i_ex2_stq_haz) ? LDQ_STQ_HAZ : LDQ_EX3_DONE;
        end
      end
      LDQ_STQ_HAZ: begin
        if (w_br_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else begin
          w_entry_next.stq_haz = w_stq_haz_next;
          if (w_stq_haz_next == '0) begin
            w_entry_next.state = LDQ_ISSUE_WAIT;
          end
        end
      end
      LDQ_EX3_DONE: begin
        w_entry_next.state = w_br_flush ? LDQ_DEAD : LDQ_WAIT_COMPLETE;
      end
      LDQ_WAIT_COMPLETE, LDQ_DEAD: begin
        // both leave only through their own commit
        if (w_commit_match) begin
          w_entry_next.state = LDQ_INIT;
          w_entry_next.valid = 1'b0;
        end
      end
      default: begin
        w_entry_next.state = LDQ_INIT;
        w_entry_next.valid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_entry.valid   <= 1'b0;
      r_entry.state   <= LDQ_INIT;
      r_entry.stq_haz <= '0;
    end else begin
      r_entry <= w_entry_next;
    end
  end

endmodule

// File: hw/onehot_mux.sv
`timescale 1ns/1ps

module onehot_mux #(
  parameter type T = logic,
  parameter int  N = 2
) (
  input  logic [N-1:0]  i_sel,
  input  T              i_data [N],
  output T              o_data
);

  logic [$bits(T)-1:0] w_acc;

  // unselected inputs contribute zero
  always_comb begin
    w_acc = '0;
    for (int i = 0; i < N; i++) begin
      if (i_sel[i]) begin
        w_acc = w_acc | i_data[i];
      end
    end
  end

  assign o_data = T'(w_acc);

endmodule

// File: hw/ldq.sv
`timescale 1ns/1ps
`include "ldq_params.svh"

module ldq (
  input  logic                             i_clk,
  input  logic                             i_reset_n,

  input  logic                             i_disp_valid,
  input  core_pkg::cmt_id_t                i_disp_cmt_id,
  input  core_pkg::br_mask_t               i_disp_br_mask,
  input  logic                             i_disp_rs1_valid,
  input  core_pkg::rnid_t                  i_disp_rs1_rnid,
  input  logic                             i_disp_rs1_ready,
  output logic                             o_disp_ready,

  input  logic [`PHY_WR_NUM-1:0]           i_phy_wr_valid,
  input  core_pkg::rnid_t                  i_phy_wr_rnid [`PHY_WR_NUM],

  input  logic                             i_issue_stall,
  output logic                             o_issue_valid,
  output logic [$clog2(`LDQ_SIZE)-1:0]     o_issue_index,
  output ldq_pkg::ldq_issue_t              o_issue_payload,

  input  logic                             i_ex1_valid,
  input  logic [$clog2(`LDQ_SIZE)-1:0]     i_ex1_index,
  input  logic                             i_ex1_tlb_miss,
  input  logic [`PADDR_W-1:0]              i_ex1_paddr,
  input  logic                             i_tlb_resolve,

  input  logic                             i_ex2_valid,
  input  logic [$clog2(`LDQ_SIZE)-1:0]     i_ex2_index,
  input  logic [`STQ_SIZE-1:0]             i_ex2_stq_haz,
  input  logic                             i_stq_resolve_valid,
  input  logic [`STQ_SIZE-1:0]             i_stq_resolve_oh,

  input  logic                             i_commit_valid,
  input  core_pkg::cmt_id_t                i_commit_cmt_id,

  input  logic                             i_br_update,
  input  logic                             i_br_mispredict,
  input  core_pkg::br_tag_t                i_br_tag,

  output logic                             o_finish_valid,
  output core_pkg::cmt_id_t                o_finish_cmt_id
);

  import core_pkg::*;
  import ldq_pkg::*;

  localparam int IDX_W = $clog2(`LDQ_SIZE);

  ldq_entry_t             w_entries    [`LDQ_SIZE];
  ldq_issue_t             w_issue_data [`LDQ_SIZE];
  cmt_id_t                w_cmt_ids    [`LDQ_SIZE];
  logic [`LDQ_SIZE-1:0]   w_free;
  logic [`LDQ_SIZE-1:0]   w_disp_oh;
  logic [`LDQ_SIZE-1:0]   w_ready;
  logic [`LDQ_SIZE-1:0]   w_issue_oh;
  logic [`LDQ_SIZE-1:0]   w_finish;
  logic [IDX_W-1:0]       w_issue_index;

  always_comb begin
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      w_free[i]       = (w_entries[i].state == LDQ_INIT);
      w_issue_data[i] = '{cmt_id: w_entries[i].cmt_id, rs1_rnid: w_entries[i].rs1_rnid};
      w_cmt_ids[i]    = w_entries[i].cmt_id;
    end
  end

  // lowest set bit wins for both dispatch and issue
  assign w_disp_oh  = w_free & (~w_free + 1'b1);
  assign w_issue_oh = w_ready & (~w_ready + 1'b1);

  always_comb begin
    w_issue_index = '0;
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      if (w_issue_oh[i]) begin
        w_issue_index = IDX_W'(i);
      end
    end
  end

  assign o_disp_ready   = |w_free;
  assign o_issue_valid  = (|w_ready) & ~i_issue_stall;
  assign o_issue_index  = w_issue_index;
  assign o_finish_valid = |w_finish;

  for (genvar g = 0; g < `LDQ_SIZE; g++) begin : g_entry
    ldq_entry u_entry (
      .i_clk               (i_clk),
      .i_reset_n           (i_reset_n),
      .i_disp_load         (i_disp_valid & w_disp_oh[g]),
      .i_disp_cmt_id       (i_disp_cmt_id),
      .i_disp_br_mask      (i_disp_br_mask),
      .i_disp_rs1_valid    (i_disp_rs1_valid),
      .i_disp_rs1_rnid     (i_disp_rs1_rnid),
      .i_disp_rs1_ready    (i_disp_rs1_ready),
      .i_phy_wr_valid      (i_phy_wr_valid),
      .i_phy_wr_rnid       (i_phy_wr_rnid),
      .i_picked            (w_issue_oh[g] & ~i_issue_stall),  // stall holds everything
      .i_ex1_valid         (i_ex1_valid & (i_ex1_index == IDX_W'(g))),
      .i_ex1_tlb_miss      (i_ex1_tlb_miss),
      .i_ex1_paddr         (i_ex1_paddr),
      .i_tlb_resolve       (i_tlb_resolve),
      .i_ex2_valid         (i_ex2_valid & (i_ex2_index == IDX_W'(g))),
      .i_ex2_stq_haz       (i_ex2_stq_haz),
      .i_stq_resolve_valid (i_stq_resolve_valid),
      .i_stq_resolve_oh    (i_stq_resolve_oh),
      .i_commit_valid      (i_commit_valid),
      .i_commit_cmt_id     (i_commit_cmt_id),
      .i_br_update         (i_br_update),
      .i_br_mispredict     (i_br_mispredict),
      .i_br_tag            (i_br_tag),
      .o_entry             (w_entries[g]),
      .o_ready             (w_ready[g]),
      .o_finish            (w_finish[g])
    );
  end

  onehot_mux #(
    .T (ldq_issue_t),
    .N (`LDQ_SIZE)
  ) u_issue_mux (
    .i_sel  (w_issue_oh),
    .i_data (w_issue_data),
    .o_data (o_issue_payload)
  );

  // commit IDs are unique, so at most one finish bit is set
  onehot_mux #(
    .T (cmt_id_t),
    .N (`LDQ_SIZE)
  ) u_finish_mux (
    .i_sel  (w_finish),
    .i_data (w_cmt_ids),
    .o_data (o_finish_cmt_id)
  );

endmodule

// File: tests/ldq_tb.sv
`timescale 1ns/1ps
`include "ldq_params.svh"

module ldq_tb;

  import core_pkg::*;
  import ldq_pkg::*;

  localparam int IDX_W = $clog2(`LDQ_SIZE);

  typedef logic [8*12-1:0] word_t;

  logic                    i_clk;
  logic                    i_reset_n;
  logic                    i_disp_valid;
  cmt_id_t                 i_disp_cmt_id;
  br_mask_t                i_disp_br_mask;
  logic                    i_disp_rs1_valid;
  rnid_t                   i_disp_rs1_rnid;
  logic                    i_disp_rs1_ready;
  logic                    o_disp_ready;
  logic [`PHY_WR_NUM-1:0]  i_phy_wr_valid;
  rnid_t                   i_phy_wr_rnid [`PHY_WR_NUM];
  logic                    i_issue_stall;
  logic                    o_issue_valid;
  logic [IDX_W-1:0]        o_issue_index;
  ldq_issue_t              o_issue_payload;
  logic                    i_ex1_valid;
  logic [IDX_W-1:0]        i_ex1_index;
  logic                    i_ex1_tlb_miss;
  logic [`PADDR_W-1:0]     i_ex1_paddr;
  logic                    i_tlb_resolve;
  logic                    i_ex2_valid;
  logic [IDX_W-1:0]        i_ex2_index;
  logic [`STQ_SIZE-1:0]    i_ex2_stq_haz;
  logic                    i_stq_resolve_valid;
  logic [`STQ_SIZE-1:0]    i_stq_resolve_oh;
  logic                    i_commit_valid;
  cmt_id_t                 i_commit_cmt_id;
  logic                    i_br_update;
  logic                    i_br_mispredict;
  br_tag_t                 i_br_tag;
  logic                    o_finish_valid;
  cmt_id_t                 o_finish_cmt_id;

  word_t  cmd_q  [$];
  string  name_q [$];
  int     arg_q  [$];   // five operands per command
  rnid_t  disp_rnid [1 << `CMT_ID_W];  // base register of each load, by commit ID
  int     budget;
  bit     loaded;
  bit     in_test;
  string  cur_name;
  int     test_errors;
  int     error_count;
  int     tests_passed;
  int     tests_failed;

  ldq i_ldq (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic int arg_count(word_t w);
    int n;
    case (w)
      "disp": n = 5;
      "ex1", "issue": n = 3;
      "ex2", "br", "fin", "wake": n = 2;
      "stall", "stq", "quiet", "ready": n = 1;
      "tlb", "test": n = 0;
      default: n = -1;
    endcase
    return n;
  endfunction

  task automatic load_tests(output bit ok);
    int fd;
    int n;
    int v;
    word_t word;
    logic [8*24-1:0] name;
    logic [8*120-1:0] rest;
    int args [5];
    ok = 1'b1;
    budget = 0;
    fd = $fopen("tests/ldq_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/ldq_tests.txt");
      ok = 1'b0;
    end else begin
      word = '0;
      while (ok && $fscanf(fd, "%s", word) == 1) begin
        name = '0;
        args = '{default: 0};
        n = arg_count(word);
        if (word == "#") begin
          void'($fgets(rest, fd));
        end else if (n < 0) begin
          $display("unknown command %0s in the test file", string'(word));
          ok = 1'b0;
        end else begin
          if (word == "test") begin
            void'($fscanf(fd, "%s", name));
          end
          for (int k = 0; k < n; k++) begin
            v = 0;
            if ($fscanf(fd, "%h", v) != 1) begin
              ok = 1'b0;
            end
            args[k] = v;
          end
          case (word)
            "issue": budget += args[2];
            "fin": budget += args[1];
            "quiet": budget += args[0];
            "stall", "ready", "test": begin
            end
            default: budget += 1;
          endcase
          cmd_q.push_back(word);
          name_q.push_back(string'(name));
          for (int k = 0; k < 5; k++) begin
            arg_q.push_back(args[k]);
          end
        end
        word = '0;
      end
      $fclose(fd);
    end
  endtask

  task automatic clear_pulses();
    i_disp_valid        = 1'b0;
    i_phy_wr_valid      = '0;
    i_ex1_valid         = 1'b0;
    i_tlb_resolve       = 1'b0;
    i_ex2_valid         = 1'b0;
    i_stq_resolve_valid = 1'b0;
    i_commit_valid      = 1'b0;
    i_br_update         = 1'b0;
    i_br_mispredict     = 1'b0;
  endtask

  // inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge i_clk);
    #1;
    clear_pulses();
  endtask

  task automatic log_mismatch(input string sig, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    $display("Mismatch %0s: expected %0h, got %0h", sig, exp_v, act_v);
    test_errors++;
    error_count++;
  endtask

  task automatic fail_check(input string what);
    $display("%0s", what);
    test_errors++;
    error_count++;
  endtask

  task automatic close_test();
    if (in_test) begin
      if (test_errors == 0) begin
        $display("test %0s: passed", cur_name);
        tests_passed++;
      end else begin
        $display("test %0s: failed with %0d errors", cur_name, test_errors);
        tests_failed++;
      end
    end
    test_errors = 0;
  endtask

  task automatic wait_issue(input int idx, input int cmt, input int bound);
    bit seen;
    rnid_t exp_rnid;
    seen = 1'b0;
    exp_rnid = disp_rnid[cmt[`CMT_ID_W-1:0]];
    for (int k = 0; k < bound && !seen; k++) begin
      #4;  // sample mid cycle
      if (o_issue_valid === 1'b1) begin
        seen = 1'b1;
        if (o_issue_index !== idx[IDX_W-1:0]) begin
          log_mismatch("o_issue_index", idx, o_issue_index);
        end
        if (o_issue_payload.cmt_id !== cmt[`CMT_ID_W-1:0]) begin
          log_mismatch("o_issue_payload.cmt_id", cmt, o_issue_payload.cmt_id);
        end
        if (o_issue_payload.rs1_rnid !== exp_rnid) begin
          log_mismatch("o_issue_payload.rs1_rnid", exp_rnid, o_issue_payload.rs1_rnid);
        end
      end
      next_cycle();
    end
    if (!seen) begin
      fail_check($sformatf("load %0h was not issued within %0d cycles", cmt, bound));
    end
  endtask

  // commit is repeated until the entry frees
  task automatic wait_finish(input int cmt, input int bound);
    bit seen;
    seen = 1'b0;
    for (int k = 0; k < bound && !seen; k++) begin
      i_commit_valid  = 1'b1;
      i_commit_cmt_id = cmt_id_t'(cmt);
      #4;
      if (o_finish_valid === 1'b1) begin
        seen = 1'b1;
        if (o_finish_cmt_id !== cmt[`CMT_ID_W-1:0]) begin
          log_mismatch("o_finish_cmt_id", cmt, o_finish_cmt_id);
        end
      end
      next_cycle();
    end
    if (!seen) begin
      fail_check($sformatf("load %0h did not finish within %0d cycles", cmt, bound));
    end
  endtask

  task automatic run_command(input int c);
    word_t w;
    int a [5];
    w = cmd_q[c];
    for (int k = 0; k < 5; k++) begin
      a[k] = arg_q[c*5+k];
    end
    case (w)
      "test": begin
        close_test();
        cur_name = name_q[c];
        in_test  = 1'b1;
      end
      "stall": i_issue_stall = a[0][0];
      "ready": begin
        if (o_disp_ready !== a[0][0]) begin
          log_mismatch("o_disp_ready", a[0], o_disp_ready);
        end
      end
      "disp": begin
        i_disp_valid     = 1'b1;
        i_disp_cmt_id    = cmt_id_t'(a[0]);
        i_disp_br_mask   = br_mask_t'(a[1]);
        i_disp_rs1_valid = a[2][0];
        i_disp_rs1_rnid  = rnid_t'(a[3]);
        i_disp_rs1_ready = a[4][0];
        disp_rnid[a[0][`CMT_ID_W-1:0]] = rnid_t'(a[3]);
        next_cycle();
      end
      "wake": begin
        i_phy_wr_valid[a[0]] = 1'b1;
        i_phy_wr_rnid[a[0]]  = rnid_t'(a[1]);
        next_cycle();
      end
      "ex1": begin
        i_ex1_valid    = 1'b1;
        i_ex1_index    = a[0][IDX_W-1:0];
        i_ex1_tlb_miss = a[1][0];
        i_ex1_paddr    = a[2][`PADDR_W-1:0];
        next_cycle();
      end
      "ex2": begin
        i_ex2_valid   = 1'b1;
        i_ex2_index   = a[0][IDX_W-1:0];
        i_ex2_stq_haz = a[1][`STQ_SIZE-1:0];
        next_cycle();
      end
      "tlb": begin
        i_tlb_resolve = 1'b1;
        next_cycle();
      end
      "stq": begin
        i_stq_resolve_valid = 1'b1;
        i_stq_resolve_oh    = a[0][`STQ_SIZE-1:0];
        next_cycle();
      end
      "br": begin
        i_br_update     = 1'b1;
        i_br_tag        = br_tag_t'(a[0]);
        i_br_mispredict = a[1][0];
        next_cycle();
      end
      "quiet": begin
        for (int k = 0; k < a[0]; k++) begin
          #4;
          if (o_issue_valid !== 1'b0) begin
            log_mismatch("o_issue_valid", 0, o_issue_valid);
          end
          if (o_finish_valid !== 1'b0) begin
            log_mismatch("o_finish_valid", 0, o_finish_valid);
          end
          next_cycle();
        end
      end
      "issue": wait_issue(a[0], a[1], a[2]);
      "fin": wait_finish(a[0], a[1]);
      default: fail_check("unknown command reached the run loop");
    endcase
  endtask

  initial begin : watchdog
    wait (loaded);
    #((budget + 64) * 10);
    $display("timeout after %0d cycles, the DUT stopped responding", budget + 64);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    bit ok;
    i_reset_n        = 1'b0;
    i_issue_stall    = 1'b0;
    i_disp_cmt_id    = '0;
    i_disp_br_mask   = '0;
    i_disp_rs1_valid = 1'b0;
    i_disp_rs1_rnid  = '0;
    i_disp_rs1_ready = 1'b0;
    for (int b = 0; b < `PHY_WR_NUM; b++) begin
      i_phy_wr_rnid[b] = '0;
    end
    i_ex1_index      = '0;
    i_ex1_tlb_miss   = 1'b0;
    i_ex1_paddr      = '0;
    i_ex2_index      = '0;
    i_ex2_stq_haz    = '0;
    i_stq_resolve_oh = '0;
    i_commit_cmt_id  = '0;
    i_br_tag         = '0;
    clear_pulses();
    load_tests(ok);
    if (!ok) begin
      $display("the test file could not be read");
      $display("STATUS: FAIL");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (5) @(posedge i_clk);
      #1;
      i_reset_n = 1'b1;
      for (int c = 0; c < cmd_q.size(); c++) begin
        run_command(c);
      end
      close_test();
      $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
               error_count);
      if (tests_failed == 0 && error_count == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

endmodule

// File: all.f
+incdir+common
common/core_pkg.sv
common/ldq_pkg.sv
ldq/phy_wr_select.sv
ldq/ldq_entry.sv
hw/onehot_mux.sv
hw/ldq.sv
tests/ldq_tb.sv

// File: tests/ldq_tests.txt
# command then hex operands; issue <idx> <cmt> <bound>, fin <cmt> <bound>, quiet <cycles>
# disp <cmt> <br_mask> <rs1_valid> <rnid> <rs1_ready>, wake <bus> <rnid>, ready <expected>
test reset
ready 1
quiet 3
test issue_order
stall 1
disp 01 0 1 05 1
disp 02 0 1 06 1
quiet 3
stall 0
issue 0 01 1
issue 1 02 1
ex1 0 0 1000
ex2 0 0
ex1 1 0 1040
ex2 1 0
fin 01 4
fin 02 4
test wakeup
disp 03 0 1 0a 0
quiet 3
wake 1 0a
issue 0 03 1
ex1 0 0 2000
ex2 0 0
fin 03 3
test tlb_miss
disp 04 0 0 00 0
issue 0 04 1
ex1 0 1 3000
quiet 4
tlb
issue 0 04 1
ex1 0 0 3000
ex2 0 0
fin 04 3
test stq_haz
disp 05 0 1 07 1
issue 0 05 1
ex1 0 0 4000
ex2 0 6
quiet 2
stq 2
quiet 2
stq 4
issue 0 05 1
ex1 0 0 4000
ex2 0 0
fin 05 3
test mispredict
stall 1
disp 06 2 1 08 1
disp 07 1 1 09 1
br 1 1
stall 0
issue 1 07 1
quiet 3
ex1 1 0 5000
ex2 1 0
fin 06 1
fin 07 3
test full
stall 1
disp 08 0 1 0b 1
disp 09 0 1 0c 1
disp 0a 0 1 0d 1
ready 1
disp 0b 0 1 0e 1
ready 0
stall 0
issue 0 08 1
ex1 0 0 6000
ex2 0 0
fin 08 3
ready 1
